// ==== verilog.f ====
+incdir+testbench
hw/rv_isa_pkg.sv
hw/id_ctrl_pkg.sv
hw/imm_gen.sv
hw/alu_decoder.sv
hw/mem_decoder.sv
hw/flow_decoder.sv
hw/id_decoder.sv
hw/id_ex_reg.sv
hw/id_stage.sv
testbench/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - hw/rv_isa_pkg.sv
  - hw/id_ctrl_pkg.sv
  - hw/imm_gen.sv
  - hw/alu_decoder.sv
  - hw/mem_decoder.sv
  - hw/flow_decoder.sv
  - hw/id_decoder.sv
  - hw/id_ex_reg.sv
  - hw/id_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_id_stage.sv

// ==== testbench/tb_id_tests.svh ====
function automatic logic [63:0] sext(input logic [63:0] v, input int bits);
    logic [63:0] t;
    t = v << (64 - bits);
    return $signed(t) >>> (64 - bits);
endfunction

function automatic reg_addr_t rand_reg();
    return 5'($random(seed));
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3,
                                      input reg_addr_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

task automatic test_reset;
    int i;
    for (i = 0; i < 4; i++) begin
        @(posedge clk);
        if (i == 3) begin
            rst <= 1'b0;  // released after the 4th edge
        end
        @(negedge clk);
        check("ex_valid", 0, ex_valid);
        compare_ctrl('0);
    end
endtask

task automatic alu_case(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                        input alu_op_e op);
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic [11:0] imm12;
    logic        is_imm;
    logic [31:0] w;
    id_ctrl_t    e;
    rs1    = rand_reg();
    rs2    = rand_reg();
    rd     = rand_reg();
    imm12  = 12'($random(seed));
    is_imm = (opc == op_imm) || (opc == op_imm_w);
    if (is_imm && (f3 == 3'b001 || f3 == 3'b101)) begin
        if (opc == op_imm) begin
            imm12 = {f7[6:1], imm12[5:0]};  // 6-bit shamt
        end else begin
            imm12 = {f7, imm12[4:0]};
        end
    end
    w = is_imm ? enc_i(imm12, rs1, f3, rd, opc) : enc_r(f7, rs2, rs1, f3, rd, opc);
    e         = '0;
    e.rs1     = rs1;
    e.rs2     = is_imm ? 5'd0 : rs2;
    e.rd      = rd;
    e.reg_wen = 1'b1;
    e.alu_op  = op;
    e.src_b   = is_imm ? src_b_imm : src_b_reg;
    e.word_op = (opc == op_reg_w) || (opc == op_imm_w);
    e.imm     = is_imm ? sext(imm12, 12) : 64'd0;
    issue(w);
    compare_ctrl(e);
endtask

task automatic test_int_ops;
    repeat (3) begin
        alu_case(op_imm, 3'b000, f7_base, alu_add);    // addi
        alu_case(op_imm, 3'b010, f7_base, alu_slt);    // slti
        alu_case(op_imm, 3'b100, f7_base, alu_xor);    // xori
        alu_case(op_imm, 3'b001, f7_base, alu_sll);    // slli
        alu_case(op_imm, 3'b101, f7_alt, alu_sra);     // srai
        alu_case(op_reg, 3'b000, f7_base, alu_add);
        alu_case(op_reg, 3'b000, f7_alt, alu_sub);
        alu_case(op_reg, 3'b101, f7_alt, alu_sra);
        alu_case(op_reg_w, 3'b000, f7_base, alu_add);  // addw
        alu_case(op_reg_w, 3'b000, f7_alt, alu_sub);   // subw
        alu_case(op_imm_w, 3'b000, f7_base, alu_add);  // addiw
        alu_case(op_imm_w, 3'b101, f7_alt, alu_sra);   // sraiw
        alu_case(op_reg_w, 3'b001, f7_base, alu_sll);  // sllw
    end
endtask

task automatic mem_case(input logic store, input logic [2:0] f3, input mem_size_e size,
                        input logic uns);
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic [11:0] off;
    id_ctrl_t    e;
    rs1 = rand_reg();
    rs2 = rand_reg();
    rd  = rand_reg();
    off = 12'($random(seed));
    e                   = '0;
    e.rs1               = rs1;
    e.src_b             = src_b_imm;
    e.imm               = sext(off, 12);
    e.mem.size          = size;
    e.mem.load_unsigned = uns;
    if (store) begin
        e.rs2       = rs2;
        e.mem.store = 1'b1;
        issue(enc_s(off, rs2, rs1, f3));
    end else begin
        e.rd       = rd;
        e.reg_wen  = 1'b1;
        e.mem.load = 1'b1;
        issue(enc_i(off, rs1, f3, rd, op_load));
    end
    compare_ctrl(e);
endtask

task automatic test_mem;
    mem_case(1'b0, 3'b000, mem_byte, 1'b0);   // lb
    mem_case(1'b0, 3'b001, mem_half, 1'b0);   // lh
    mem_case(1'b0, 3'b010, mem_word, 1'b0);   // lw
    mem_case(1'b0, 3'b011, mem_dword, 1'b0);  // ld
    mem_case(1'b0, 3'b100, mem_byte, 1'b1);   // lbu
    mem_case(1'b0, 3'b101, mem_half, 1'b1);   // lhu
    mem_case(1'b0, 3'b110, mem_word, 1'b1);   // lwu
    mem_case(1'b1, 3'b000, mem_byte, 1'b0);   // sb
    mem_case(1'b1, 3'b001, mem_half, 1'b0);   // sh
    mem_case(1'b1, 3'b010, mem_word, 1'b0);   // sw
    mem_case(1'b1, 3'b011, mem_dword, 1'b0);  // sd
endtask

task automatic branch_case(input logic [2:0] f3, input br_cond_e cond);
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [12:0] off;
    id_ctrl_t    e;
    rs1 = rand_reg();
    rs2 = rand_reg();
    off = {12'($random(seed)), 1'b0};
    e         = '0;
    e.rs1     = rs1;
    e.rs2     = rs2;
    e.branch  = 1'b1;
    e.br_cond = cond;
    e.imm     = sext(off, 13);
    issue(enc_b(off, rs2, rs1, f3));
    compare_ctrl(e);
endtask

task automatic jump_case(input logic is_jalr);
    reg_addr_t   rs1;
    reg_addr_t   rd;
    logic [20:0] off;
    id_ctrl_t    e;
    rs1 = rand_reg();
    rd  = rand_reg();
    off = {20'($random(seed)), 1'b0};
    e         = '0;
    e.rd      = rd;
    e.reg_wen = 1'b1;
    e.src_a   = src_a_pc;
    e.src_b   = src_b_four;
    e.jump    = 1'b1;
    if (is_jalr) begin
        e.rs1  = rs1;
        e.jalr = 1'b1;
        e.imm  = sext(off[11:0], 12);
        issue(enc_i(off[11:0], rs1, 3'b000, rd, op_jalr));
    end else begin
        e.imm = sext(off, 21);
        issue(enc_j(off, rd));
    end
    compare_ctrl(e);
endtask

task automatic upper_case(input logic is_lui);
    reg_addr_t   rd;
    logic [19:0] upper;
    id_ctrl_t    e;
    rd    = rand_reg();
    upper = 20'($random(seed));
    e         = '0;
    e.rd      = rd;
    e.reg_wen = 1'b1;
    e.src_a   = is_lui ? src_a_zero : src_a_pc;
    e.src_b   = src_b_imm;
    e.imm     = sext({upper, 12'b0}, 32);
    issue({upper, rd, is_lui ? op_lui : op_auipc});
    compare_ctrl(e);
endtask

task automatic test_flow;
    branch_case(3'b000, br_eq);
    branch_case(3'b001, br_ne);
    branch_case(3'b100, br_lt);
    branch_case(3'b101, br_ge);
    branch_case(3'b110, br_ltu);
    branch_case(3'b111, br_geu);
    jump_case(1'b0);
    jump_case(1'b1);
    upper_case(1'b1);
    upper_case(1'b0);
endtask

task automatic expect_word(input logic [31:0] w, input trap_e t, input logic bad);
    id_ctrl_t e;
    e         = '0;
    e.trap    = t;
    e.illegal = bad;
    issue(w);
    compare_ctrl(e);
endtask

task automatic test_traps;
    expect_word(inst_ecall, trap_ecall, 1'b0);
    expect_word(inst_ebreak, trap_ebreak, 1'b0);
    expect_word(inst_mret, trap_mret, 1'b0);
endtask

task automatic test_illegal;
    logic [6:0]  unused_op [0:4] = '{7'b0001111, 7'b0101111, 7'b1010011,
                                     7'b1011011, 7'b1111011};
    logic [31:0] w;
    int          i;
    int          bit_pos;
    expect_word(enc_r(7'b0000001, rand_reg(), rand_reg(), 3'b000, rand_reg(), op_reg),
                trap_none, 1'b1);  // mul
    expect_word(enc_r(7'b0000001, rand_reg(), rand_reg(), 3'b100, rand_reg(), op_reg_w),
                trap_none, 1'b1);  // divw
    expect_word(enc_i(12'h300, rand_reg(), 3'b001, rand_reg(), op_system),
                trap_none, 1'b1);  // csrrw
    // single-bit flips kept out of the opcode field
    for (i = 0; i < 6; i++) begin
        w       = (i % 3 == 0) ? inst_ecall : ((i % 3 == 1) ? inst_ebreak : inst_mret);
        bit_pos = 7 + ($unsigned($random(seed)) % 24);
        if (bit_pos >= 20) begin
            bit_pos++;  // bit 20 alone maps ecall and ebreak onto each other
        end
        w = w ^ (32'h1 << bit_pos);
        expect_word(w, trap_none, 1'b1);
    end
    for (i = 0; i < 5; i++) begin
        w      = $random(seed);
        w[6:0] = unused_op[$unsigned($random(seed)) % 5];
        expect_word(w, trap_none, 1'b1);
    end
endtask

task automatic test_pipeline;
    reg_addr_t   rs1_a;
    reg_addr_t   rd_a;
    reg_addr_t   rd_b;
    logic [11:0] imm_a;
    logic [19:0] imm_b;
    id_ctrl_t    ea;
    id_ctrl_t    eb;
    int          i;
    int          edges;
    rs1_a = rand_reg();
    rd_a  = rand_reg();
    rd_b  = rand_reg();
    imm_a = 12'($random(seed));
    imm_b = 20'($random(seed));
    ea         = '0;  // addi
    ea.rs1     = rs1_a;
    ea.rd      = rd_a;
    ea.reg_wen = 1'b1;
    ea.src_b   = src_b_imm;
    ea.imm     = sext(imm_a, 12);
    eb         = '0;  // lui
    eb.rd      = rd_b;
    eb.reg_wen = 1'b1;
    eb.src_a   = src_a_zero;
    eb.src_b   = src_b_imm;
    eb.imm     = sext({imm_b, 12'b0}, 32);

    issue(enc_i(imm_a, rs1_a, 3'b000, rd_a, op_imm));
    compare_ctrl(ea);
    @(posedge clk);
    stall <= 1'b1;
    inst  <= {imm_b, rd_b, op_lui};
    for (i = 0; i < 4; i++) begin
        @(negedge clk);
        check("ex_valid", 1, ex_valid);
        compare_ctrl(ea);
    end

    @(posedge clk);
    flush <= 1'b1;  // while still stalled
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    check("ex_valid", 0, ex_valid);
    compare_ctrl(ea);

    @(posedge clk);
    stall <= 1'b0;
    wait_valid(1'b1, edges);
    check("release latency", 1, edges);
    compare_ctrl(eb);

    @(posedge clk);
    inst_valid <= 1'b0;
    wait_valid(1'b0, edges);
    check("idle latency", 1, edges);
endtask

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/100ps

module tb_id_stage;

    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    localparam int wait_limit = 8;  // cycles per wait loop

    logic     clk;
    logic     rst;
    logic     inst_valid;
    inst_t    inst;
    logic     stall;
    logic     flush;
    logic     ex_valid;
    id_ctrl_t ex_ctrl;
    integer   seed;

    id_stage uut (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .stall      (stall),
        .flush      (flush),
        .ex_valid   (ex_valid),
        .ex_ctrl    (ex_ctrl)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic compare_ctrl(input id_ctrl_t e);
        check("ex_ctrl.rs1", e.rs1, ex_ctrl.rs1);
        check("ex_ctrl.rs2", e.rs2, ex_ctrl.rs2);
        check("ex_ctrl.rd", e.rd, ex_ctrl.rd);
        check("ex_ctrl.reg_wen", e.reg_wen, ex_ctrl.reg_wen);
        check("ex_ctrl.alu_op", e.alu_op, ex_ctrl.alu_op);
        check("ex_ctrl.src_a", e.src_a, ex_ctrl.src_a);
        check("ex_ctrl.src_b", e.src_b, ex_ctrl.src_b);
        check("ex_ctrl.word_op", e.word_op, ex_ctrl.word_op);
        check("ex_ctrl.imm", e.imm, ex_ctrl.imm);
        check("ex_ctrl.mem", e.mem, ex_ctrl.mem);
        check("ex_ctrl.branch", e.branch, ex_ctrl.branch);
        check("ex_ctrl.br_cond", e.br_cond, ex_ctrl.br_cond);
        check("ex_ctrl.jump", e.jump, ex_ctrl.jump);
        check("ex_ctrl.jalr", e.jalr, ex_ctrl.jalr);
        check("ex_ctrl.trap", e.trap, ex_ctrl.trap);
        check("ex_ctrl.illegal", e.illegal, ex_ctrl.illegal);
    endtask

    // counts rising edges until ex_valid settles at level
    task automatic wait_valid(input logic level, output int edges);
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (ex_valid !== level && edges < wait_limit);
        if (ex_valid !== level) begin
            $display("timeout: ex_valid did not reach %0b within %0d cycles", level, wait_limit);
            $display("=== FAIL ===");
            $fatal(1, "wait for ex_valid timed out");
        end
    endtask

    task automatic issue(input logic [31:0] w);
        int edges;
        @(posedge clk);
        inst       <= w;
        inst_valid <= 1'b1;
        wait_valid(1'b1, edges);
        check("stage latency", 1, edges);
    endtask

    `include "tb_id_tests.svh"

    initial begin
        seed       = 61;
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        stall      = 1'b0;
        flush      = 1'b0;

        test_reset();
        test_int_ops();
        test_mem();
        test_flow();
        test_traps();
        test_illegal();
        test_pipeline();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/100ps

module id_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_valid,
    input  rv_isa_pkg::inst_t      inst,
    input  logic                   stall,
    input  logic                   flush,
    output logic                   ex_valid,
    output id_ctrl_pkg::id_ctrl_t  ex_ctrl
);

    import id_ctrl_pkg::*;

    id_ctrl_t dec_ctrl;

    id_decoder u_id_decoder (
        .inst (inst),
        .ctrl (dec_ctrl)
    );

    id_ex_reg u_id_ex_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (inst_valid),
        .stall     (stall),
        .flush     (flush),
        .in_ctrl   (dec_ctrl),
        .out_valid (ex_valid),
        .out_ctrl  (ex_ctrl)
    );

endmodule

// ==== hw/id_ex_reg.sv ====
`timescale 1ns/100ps

module id_ex_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  logic                   stall,
    input  logic                   flush,
    input  id_ctrl_pkg::id_ctrl_t  in_ctrl,
    output logic                   out_valid,
    output id_ctrl_pkg::id_ctrl_t  out_ctrl
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_ctrl  <= '0;
        end else begin
            if (flush) begin
                out_valid <= 1'b0;  // wins over stall
            end else if (!stall) begin
                out_valid <= in_valid;
            end

            if (!stall) begin
                out_ctrl <= in_ctrl;
            end
        end
    end

endmodule

// ==== hw/id_decoder.sv ====
`timescale 1ns/100ps

module id_decoder (
    input  rv_isa_pkg::inst_t      inst,
    output id_ctrl_pkg::id_ctrl_t  ctrl
);

    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    dec_part_t       alu_part;
    dec_part_t       mem_part;
    dec_part_t       flow_part;
    dec_part_t       sel;
    logic [xlen-1:0] imm;

    alu_decoder u_alu_dec (
        .inst (inst),
        .part (alu_part)
    );

    mem_decoder u_mem_dec (
        .inst (inst),
        .part (mem_part)
    );

    flow_decoder u_flow_dec (
        .inst (inst),
        .part (flow_part)
    );

    // groups are disjoint, at most one hit
    always_comb begin
        sel = '0;
        if (alu_part.hit) begin
            sel = alu_part;
        end else if (mem_part.hit) begin
            sel = mem_part;
        end else if (flow_part.hit) begin
            sel = flow_part;
        end
    end

    imm_gen u_imm_gen (
        .inst     (inst),
        .imm_type (sel.imm_type),
        .imm      (imm)
    );

    always_comb begin
        ctrl = '0;
        if (sel.hit) begin
            ctrl.rs1     = sel.uses_rs1 ? inst.rs1 : '0;
            ctrl.rs2     = sel.uses_rs2 ? inst.rs2 : '0;
            ctrl.rd      = sel.writes_rd ? inst.rd : '0;
            ctrl.reg_wen = sel.writes_rd;
            ctrl.alu_op  = sel.alu_op;
            ctrl.src_a   = sel.src_a;
            ctrl.src_b   = sel.src_b;
            ctrl.word_op = sel.word_op;
            ctrl.imm     = imm;
            ctrl.mem     = sel.mem;
            ctrl.branch  = sel.branch;
            ctrl.br_cond = sel.br_cond;
            ctrl.jump    = sel.jump;
            ctrl.jalr    = sel.jalr;
            ctrl.trap    = sel.trap;
        end else begin
            ctrl.illegal = 1'b1;  // everything else stays zero
        end
    end

endmodule

// ==== hw/flow_decoder.sv ====
`timescale 1ns/100ps

module flow_decoder (
    input  rv_isa_pkg::inst_t       inst,
    output id_ctrl_pkg::dec_part_t  part
);

    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    logic     br_ok;
    br_cond_e cond;

    always_comb begin
        br_ok = 1'b1;
        cond  = br_eq;
        case (inst.funct3)
            3'b000:  cond = br_eq;
            3'b001:  cond = br_ne;
            3'b100:  cond = br_lt;
            3'b101:  cond = br_ge;
            3'b110:  cond = br_ltu;
            3'b111:  cond = br_geu;
            default: br_ok = 1'b0;  // 010, 011 unused
        endcase
    end

    always_comb begin
        part = '0;
        case (inst.opcode)
            op_branch: begin
                if (br_ok) begin
                    part.hit      = 1'b1;
                    part.uses_rs1 = 1'b1;
                    part.uses_rs2 = 1'b1;
                    part.imm_type = imm_b;
                    part.branch   = 1'b1;
                    part.br_cond  = cond;
                end
            end
            op_jal, op_jalr: begin
                if (inst.opcode == op_jal || inst.funct3 == 3'b000) begin
                    part.hit       = 1'b1;
                    part.uses_rs1  = inst.opcode == op_jalr;
                    part.writes_rd = 1'b1;
                    part.imm_type  = (inst.opcode == op_jalr) ? imm_i : imm_j;
                    part.src_a     = src_a_pc;    // link = pc + 4
                    part.src_b     = src_b_four;
                    part.jump      = 1'b1;
                    part.jalr      = inst.opcode == op_jalr;
                end
            end
            op_lui, op_auipc: begin
                part.hit       = 1'b1;
                part.writes_rd = 1'b1;
                part.imm_type  = imm_u;
                part.src_a     = (inst.opcode == op_lui) ? src_a_zero : src_a_pc;
                part.src_b     = src_b_imm;
            end
            op_system: begin
                part.hit = 1'b1;
                case (inst)
                    inst_ecall:  part.trap = trap_ecall;
                    inst_ebreak: part.trap = trap_ebreak;
                    inst_mret:   part.trap = trap_mret;
                    default:     part.hit  = 1'b0;  // csr and the rest
                endcase
            end
            default: begin
                part = '0;
            end
        endcase
    end

endmodule

// ==== hw/mem_decoder.sv ====
`timescale 1ns/100ps

module mem_decoder (
    input  rv_isa_pkg::inst_t       inst,
    output id_ctrl_pkg::dec_part_t  part
);

    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    logic is_load;
    logic is_store;

    // loads 000..110, stores 000..011
    assign is_load  = (inst.opcode == op_load) && (inst.funct3 != 3'b111);
    assign is_store = (inst.opcode == op_store) && !inst.funct3[2];

    always_comb begin
        part = '0;
        if (is_load || is_store) begin
            part.hit       = 1'b1;
            part.uses_rs1  = 1'b1;
            part.uses_rs2  = is_store;  // store data
            part.writes_rd = is_load;
            part.imm_type  = is_store ? imm_s : imm_i;
            part.alu_op    = alu_add;   // base + offset
            part.src_a     = src_a_reg;
            part.src_b     = src_b_imm;

            part.mem.load          = is_load;
            part.mem.store         = is_store;
            part.mem.size          = mem_size_e'(inst.funct3[1:0]);
            part.mem.load_unsigned = inst.funct3[2];  // lbu lhu lwu
        end
    end

endmodule

// ==== hw/alu_decoder.sv ====
`timescale 1ns/100ps

module alu_decoder (
    input  rv_isa_pkg::inst_t       inst,
    output id_ctrl_pkg::dec_part_t  part
);

    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    logic grp_reg;     // OP, OP-32
    logic grp_imm;     // OP-IMM, OP-IMM-32
    logic grp_word;
    logic is_shift;
    logic f7_is_base;
    logic f7_is_alt;
    logic sh6_base;
    logic sh6_alt;
    logic f3_alt_ok;
    logic alt;
    logic legal;

    function automatic alu_op_e f3_op(input logic [funct3_w-1:0] f3, input logic alt_sel);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt_sel ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt_sel ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign grp_reg  = (inst.opcode == op_reg) || (inst.opcode == op_reg_w);
    assign grp_imm  = (inst.opcode == op_imm) || (inst.opcode == op_imm_w);
    assign grp_word = (inst.opcode == op_reg_w) || (inst.opcode == op_imm_w);
    assign is_shift = (inst.funct3 == 3'b001) || (inst.funct3 == 3'b101);

    assign f7_is_base = inst.funct7 == f7_base;
    assign f7_is_alt  = inst.funct7 == f7_alt;
    assign sh6_base   = inst.funct7[funct7_w-1:1] == f7_base[funct7_w-1:1];  // bit 0 is shamt[5]
    assign sh6_alt    = inst.funct7[funct7_w-1:1] == f7_alt[funct7_w-1:1];

    // alt funct7 only valid for sra*, and sub* in register form
    assign f3_alt_ok = (inst.funct3 == 3'b101) || (grp_reg && inst.funct3 == 3'b000);
    assign alt       = f3_alt_ok && ((inst.opcode == op_imm) ? sh6_alt : f7_is_alt);

    always_comb begin
        case (inst.opcode)
            op_reg: begin
                legal = f7_is_base || (f7_is_alt && f3_alt_ok);
            end
            op_reg_w: begin
                legal = ((inst.funct3 == 3'b000) || is_shift) &&
                        (f7_is_base || (f7_is_alt && f3_alt_ok));
            end
            op_imm: begin
                legal = !is_shift || sh6_base || (sh6_alt && f3_alt_ok);
            end
            op_imm_w: begin
                legal = (inst.funct3 == 3'b000) ||
                        (is_shift && (f7_is_base || (f7_is_alt && f3_alt_ok)));
            end
            default: begin
                legal = 1'b0;  // not an integer-op opcode
            end
        endcase
    end

    always_comb begin
        part = '0;
        if (legal) begin
            part.hit       = 1'b1;
            part.uses_rs1  = 1'b1;
            part.uses_rs2  = grp_reg;
            part.writes_rd = 1'b1;
            part.imm_type  = grp_imm ? imm_i : imm_none;
            part.alu_op    = f3_op(inst.funct3, alt);
            part.src_a     = src_a_reg;
            part.src_b     = grp_imm ? src_b_imm : src_b_reg;
            part.word_op   = grp_word;
        end
    end

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen (
    input  rv_isa_pkg::inst_t            inst,
    input  id_ctrl_pkg::imm_type_e       imm_type,
    output logic [rv_isa_pkg::xlen-1:0]  imm
);

    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;

    logic [31:0] w;
    logic        sign;

    assign w    = inst;
    assign sign = w[31];

    always_comb begin
        case (imm_type)
            imm_i: begin
                imm = {{(xlen-12){sign}}, w[31:20]};  // shamt lives in the low bits
            end
            imm_s: begin
                imm = {{(xlen-12){sign}}, w[31:25], w[11:7]};
            end
            imm_b: begin
                imm = {{(xlen-13){sign}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            imm_u: begin
                imm = {{(xlen-32){sign}}, w[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{(xlen-21){sign}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== hw/id_ctrl_pkg.sv ====
package id_ctrl_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [1:0] {src_a_reg, src_a_pc, src_a_zero} src_a_e;
    typedef enum logic [1:0] {src_b_reg, src_b_imm, src_b_four} src_b_e;

    typedef enum logic [2:0] {imm_none, imm_i, imm_s, imm_b, imm_u, imm_j} imm_type_e;

    typedef enum logic [2:0] {br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu} br_cond_e;

    typedef enum logic [1:0] {trap_none, trap_ecall, trap_ebreak, trap_mret} trap_e;

    typedef enum logic [1:0] {mem_byte, mem_half, mem_word, mem_dword} mem_size_e;

    typedef struct packed {
        logic      load;
        logic      store;
        mem_size_e size;
        logic      load_unsigned;  // zero-extend loaded data
    } mem_ctrl_t;

    // what one group decoder reports for its own encodings
    typedef struct packed {
        logic      hit;
        logic      uses_rs1;
        logic      uses_rs2;
        logic      writes_rd;
        imm_type_e imm_type;
        alu_op_e   alu_op;
        src_a_e    src_a;
        src_b_e    src_b;
        logic      word_op;
        mem_ctrl_t mem;
        logic      branch;
        br_cond_e  br_cond;
        logic      jump;
        logic      jalr;
        trap_e     trap;
    } dec_part_t;

    typedef struct packed {
        reg_addr_t        rs1;
        reg_addr_t        rs2;
        reg_addr_t        rd;
        logic             reg_wen;
        alu_op_e          alu_op;
        src_a_e           src_a;
        src_b_e           src_b;
        logic             word_op;  // 32-bit op, result sign-extended
        logic [xlen-1:0]  imm;
        mem_ctrl_t        mem;
        logic             branch;
        br_cond_e         br_cond;
        logic             jump;
        logic             jalr;
        trap_e            trap;
        logic             illegal;
    } id_ctrl_t;

endpackage

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;

    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // overlays the raw 32-bit instruction word, msb first
    typedef struct packed {
        logic [funct7_w-1:0] funct7;
        reg_addr_t           rs2;
        reg_addr_t           rs1;
        logic [funct3_w-1:0] funct3;
        reg_addr_t           rd;
        logic [opcode_w-1:0] opcode;
    } inst_t;

    localparam logic [opcode_w-1:0] op_reg    = 7'b0110011;
    localparam logic [opcode_w-1:0] op_imm    = 7'b0010011;
    localparam logic [opcode_w-1:0] op_reg_w  = 7'b0111011;
    localparam logic [opcode_w-1:0] op_imm_w  = 7'b0011011;
    localparam logic [opcode_w-1:0] op_load   = 7'b0000011;
    localparam logic [opcode_w-1:0] op_store  = 7'b0100011;
    localparam logic [opcode_w-1:0] op_branch = 7'b1100011;
    localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;
    localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_w-1:0] op_auipc  = 7'b0010111;
    localparam logic [opcode_w-1:0] op_system = 7'b1110011;

    localparam logic [funct7_w-1:0] f7_base = 7'b0000000;
    localparam logic [funct7_w-1:0] f7_alt  = 7'b0100000;  // sub, sra

    // system words matched in full
    localparam logic [31:0] inst_ecall  = 32'h0000_0073;
    localparam logic [31:0] inst_ebreak = 32'h0010_0073;
    localparam logic [31:0] inst_mret   = 32'h3020_0073;

endpackage
